// ==== csr_pkg.sv ====
package csr_pkg;

	localparam int xlen       = 32;
	localparam int csr_addr_w = 12;
	localparam int time_w     = 64;

	// trap bank windows
	localparam logic [csr_addr_w-1:0] m_base = 12'h300;
	localparam logic [csr_addr_w-1:0] s_base = 12'h100;

	typedef enum logic [csr_addr_w-1:0] {
		csr_mvendorid = 12'hf11,
		csr_marchid   = 12'hf12,
		csr_mimpid    = 12'hf13,
		csr_mhartid   = 12'hf14,
		csr_mstatus   = 12'h300,
		csr_misa      = 12'h301,
		csr_medeleg   = 12'h302,
		csr_mideleg   = 12'h303,
		csr_mie       = 12'h304,
		csr_mtvec     = 12'h305,
		csr_mscratch  = 12'h340,
		csr_mepc      = 12'h341,
		csr_mcause    = 12'h342,
		csr_mtval     = 12'h343,
		csr_mip       = 12'h344,
		csr_mcycle    = 12'hb00,
		csr_mcycleh   = 12'hb80,
		csr_mnecycle  = 12'hbbf,	// mtimecmp
		csr_cycle     = 12'hc00,
		csr_time      = 12'hc01,
		csr_cycleh    = 12'hc80,
		csr_timeh     = 12'hc81,
		csr_sstatus   = 12'h100,
		csr_sie       = 12'h104,
		csr_stvec     = 12'h105,
		csr_sscratch  = 12'h140,
		csr_sepc      = 12'h141,
		csr_scause    = 12'h142,
		csr_stval     = 12'h143,
		csr_sip       = 12'h144
	} csr_addr_e;

	typedef enum logic [1:0] {
		u = 2'b00,
		s = 2'b01,
		r = 2'b10,	// reserved encoding
		m = 2'b11
	} priv_mode_e;

	// synchronous causes
	localparam logic [30:0] i_addr_misaligned = 31'd0;
	localparam logic [30:0] i_access_fault    = 31'd1;
	localparam logic [30:0] i_illegal         = 31'd2;
	localparam logic [30:0] breakpoint        = 31'd3;
	localparam logic [30:0] l_addr_misaligned = 31'd4;
	localparam logic [30:0] l_access_fault    = 31'd5;
	localparam logic [30:0] s_addr_misaligned = 31'd6;
	localparam logic [30:0] s_access_fault    = 31'd7;
	localparam logic [30:0] u_call            = 31'd8;
	localparam logic [30:0] s_call            = 31'd9;
	localparam logic [30:0] m_call            = 31'd11;

	// interrupt causes, used with cause bit 31 set
	localparam logic [30:0] m_int_sw    = 31'd3;
	localparam logic [30:0] m_int_timer = 31'd7;
	localparam logic [30:0] s_int_ext   = 31'd9;
	localparam logic [30:0] m_int_ext   = 31'd11;

	// mxl = 1, extensions i, m, n, s, u
	localparam logic [xlen-1:0] misa_value = 32'h4014_3100;

	typedef struct packed {
		logic                  we;
		logic [csr_addr_w-1:0] addr;
		logic [xlen-1:0]       data;
	} csr_write_t;

	typedef struct packed {
		logic            valid;
		logic [xlen-1:0] cause;	// bit 31 marks an interrupt
		logic [xlen-1:0] pc;
		logic            m_ret;
		logic            s_ret;
	} trap_req_t;

	typedef struct packed {
		logic       enter_m;
		logic       enter_s;
		logic       ret_m;
		logic       ret_s;
		priv_mode_e prev_mode;
	} trap_act_t;

	typedef struct packed {
		logic [xlen-1:0] tvec;
		logic [xlen-1:0] epc;
	} trap_vec_t;

	typedef struct packed {
		logic m_eie;
		logic m_tie;
		logic s_eie;
		logic s_tie;
	} irq_en_t;

	typedef struct packed {
		logic       sie;
		logic       mie;
		logic       spie;
		logic       mpie;
		logic       spp;
		priv_mode_e mpp;
		logic       sum;
		logic       tsr;
		logic       meie;
		logic       seie;
		logic       mtie;
		logic       stie;
	} status_t;

endpackage

// ==== csr_trap_bank.sv ====
`timescale 1ns/1ps

module csr_trap_bank
	import csr_pkg::*;
#(
	parameter logic [csr_addr_w-1:0] base = m_base
)
(
	input  logic                  clk,
	input  logic                  nrst,
	input  csr_write_t            wr,
	input  trap_act_t             act,
	input  trap_req_t             trap,
	input  logic [csr_addr_w-1:0] csr_addr_r,
	output trap_vec_t             vec,
	output logic [xlen-1:0]       rdata,
	output logic                  hit
);

	localparam logic [csr_addr_w-1:0] a_tvec    = base + 12'h005;
	localparam logic [csr_addr_w-1:0] a_scratch = base + 12'h040;
	localparam logic [csr_addr_w-1:0] a_epc     = base + 12'h041;
	localparam logic [csr_addr_w-1:0] a_cause   = base + 12'h042;
	localparam logic [csr_addr_w-1:0] a_tval    = base + 12'h043;
	localparam bit                    is_m      = (base == m_base);

	logic [xlen-1:0] tvec;
	logic [xlen-1:0] scratch;
	logic [xlen-1:0] epc;
	logic [xlen-1:0] cause;
	logic [xlen-1:0] tval;
	logic            enter;
	logic            misaligned;

	assign enter = is_m ? act.enter_m : act.enter_s;	// only our own level
	assign misaligned = !trap.cause[xlen-1] && (trap.cause[xlen-2:0] == i_addr_misaligned);

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			tvec    <= '0;
			scratch <= '0;
			epc     <= '0;
			cause   <= '0;
			tval    <= '0;
		end
		else if (enter)
		begin
			epc   <= {trap.pc[xlen-1:2], 2'b00};
			cause <= trap.cause;
			tval  <= misaligned ? {trap.pc[xlen-1:1], 1'b0} : '0;
		end
		else if (wr.we)
		begin
			case (wr.addr)
				a_tvec:    tvec    <= {wr.data[xlen-1:2], 2'b00};	// direct mode only
				a_scratch: scratch <= wr.data;
				a_epc:     epc     <= {wr.data[xlen-1:2], 2'b00};
				a_cause:   cause   <= {wr.data[xlen-1], 25'b0, wr.data[5:0]};
				a_tval:    tval    <= wr.data;
				default:   ;
			endcase
		end
	end

	assign vec.tvec = tvec;
	assign vec.epc  = epc;

	// read port for this window
	always_comb
	begin
		hit   = 1'b1;
		rdata = '0;
		case (csr_addr_r)
			a_tvec:    rdata = tvec;
			a_scratch: rdata = scratch;
			a_epc:     rdata = epc;
			a_cause:   rdata = cause;
			a_tval:    rdata = tval;
			default:   hit = 1'b0;
		endcase
	end

	// holds across writes and trap entries alike
	assert property (@(posedge clk) disable iff (!nrst) epc[1:0] == 2'b00)
		else $error("epc low bits set in bank at %h", base);

endmodule

// ==== csr_status.sv ====
`timescale 1ns/1ps

module csr_status
	import csr_pkg::*;
(
	input  logic       clk,
	input  logic       nrst,
	input  csr_write_t wr,
	input  trap_act_t  act,
	output status_t    status,
	output irq_en_t    irq_en
);

	logic       sie;
	logic       mie;
	logic       spie;
	logic       mpie;
	logic       spp;
	priv_mode_e mpp;
	logic       sum;
	logic       tsr;
	logic       meie;
	logic       seie;
	logic       mtie;
	logic       stie;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			sie  <= 1'b0;
			mie  <= 1'b0;
			spie <= 1'b0;
			mpie <= 1'b0;
			spp  <= 1'b0;
			mpp  <= m;	// reset runs in machine mode
			sum  <= 1'b0;
			tsr  <= 1'b0;
			meie <= 1'b0;
			seie <= 1'b0;
			mtie <= 1'b0;
			stie <= 1'b0;
		end
		else if (act.enter_m)
		begin
			mpie <= mie;
			mie  <= 1'b0;
			mpp  <= act.prev_mode;
		end
		else if (act.enter_s)
		begin
			spie <= sie;
			sie  <= 1'b0;
			spp  <= act.prev_mode[0];
		end
		else if (act.ret_m)
		begin
			mie  <= mpie;
			mpie <= 1'b1;
			mpp  <= u;
		end
		else if (act.ret_s)
		begin
			sie  <= spie;
			spie <= 1'b1;
			spp  <= 1'b0;
		end
		else if (wr.we)
		begin
			case (csr_addr_e'(wr.addr))
				csr_mstatus:
				begin
					sie  <= wr.data[1];
					mie  <= wr.data[3];
					spie <= wr.data[5];
					mpie <= wr.data[7];
					spp  <= wr.data[8];
					// mpp is warl, the reserved encoding is not stored
					if (wr.data[12:11] != 2'b10)
						mpp <= priv_mode_e'(wr.data[12:11]);
					sum  <= wr.data[18];
					tsr  <= wr.data[22];
				end
				csr_sstatus:
				begin
					sie  <= wr.data[1];
					spie <= wr.data[5];
					spp  <= wr.data[8];
					sum  <= wr.data[18];
				end
				csr_mie:
				begin
					stie <= wr.data[5];
					mtie <= wr.data[7];
					seie <= wr.data[9];
					meie <= wr.data[11];
				end
				csr_sie:
				begin
					stie <= wr.data[5];
					seie <= wr.data[9];
				end
				default: ;
			endcase
		end
	end

	always_comb
	begin
		status.sie  = sie;
		status.mie  = mie;
		status.spie = spie;
		status.mpie = mpie;
		status.spp  = spp;
		status.mpp  = mpp;
		status.sum  = sum;
		status.tsr  = tsr;
		status.meie = meie;
		status.seie = seie;
		status.mtie = mtie;
		status.stie = stie;
	end

	// enables gated by the global xie bits
	assign irq_en.m_eie = meie & mie;
	assign irq_en.m_tie = mtie & mie;
	assign irq_en.s_eie = seie & sie;
	assign irq_en.s_tie = stie & sie;

endmodule

// ==== csr_trap_ctrl.sv ====
`timescale 1ns/1ps

module csr_trap_ctrl
	import csr_pkg::*;
(
	input  logic            clk,
	input  logic            nrst,
	input  csr_write_t      wr,
	input  trap_req_t       trap,
	input  status_t         status,
	input  trap_vec_t       m_vec,
	input  trap_vec_t       s_vec,
	output trap_act_t       act,
	output priv_mode_e      current_mode,
	output logic [15:0]     medeleg,
	output logic [11:0]     mideleg,
	output logic [xlen-1:0] redirect_pc
);

	priv_mode_e next_mode;
	logic [3:0] code;
	logic       is_ret;
	logic       deleg_s;

	assign code   = trap.cause[3:0];
	assign is_ret = trap.m_ret | trap.s_ret;

	// delegation lookup, codes beyond the register width stay in m
	always_comb
	begin
		deleg_s = 1'b0;
		if (trap.cause[xlen-2:4] == '0)
		begin
			if (trap.cause[xlen-1])
				deleg_s = (code < 4'd12) && mideleg[code];
			else
				deleg_s = medeleg[code];
		end
	end

	always_comb
	begin
		next_mode = current_mode;
		if (trap.valid)
		begin
			if (trap.m_ret)
				next_mode = status.mpp;
			else if (trap.s_ret)
				next_mode = status.spp ? s : u;
			else
				next_mode = deleg_s ? s : m;
		end
	end

	always_comb
	begin
		act.enter_m   = trap.valid && !is_ret && (next_mode == m);
		act.enter_s   = trap.valid && !is_ret && (next_mode == s);
		act.ret_m     = trap.valid && trap.m_ret;
		act.ret_s     = trap.valid && !trap.m_ret && trap.s_ret;
		act.prev_mode = current_mode;
	end

	always_comb
	begin
		if (act.ret_m)
			redirect_pc = m_vec.epc;
		else if (act.ret_s)
			redirect_pc = s_vec.epc;
		else if (next_mode == s)
			redirect_pc = s_vec.tvec;
		else
			redirect_pc = m_vec.tvec;	// no u-level vector, machine handles it
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			current_mode <= m;
			medeleg      <= '0;
			mideleg      <= '0;
		end
		else
		begin
			current_mode <= next_mode;
			if (wr.we && csr_addr_e'(wr.addr) == csr_medeleg)
				medeleg <= wr.data[15:0];
			if (wr.we && csr_addr_e'(wr.addr) == csr_mideleg)
				mideleg <= wr.data[11:0];
		end
	end

	assert property (@(posedge clk) disable iff (!nrst)
		trap.valid |-> !(trap.m_ret && trap.s_ret))
		else $error("mret and sret on the same trap strobe");

	// relies on mpp never holding the reserved encoding
	assert property (@(posedge clk) disable iff (!nrst) current_mode != r)
		else $error("current_mode entered the reserved encoding");

endmodule

// ==== csr_timer.sv ====
`timescale 1ns/1ps

module csr_timer
	import csr_pkg::*;
(
	input  logic              clk,
	input  logic              nrst,
	input  csr_write_t        wr,
	output logic [time_w-1:0] count,
	output logic [time_w-1:0] mtimecmp,
	output logic              m_timer
);

	// free-running time and cycle source
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			count <= '0;
		else
			count <= count + 1'b1;
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			mtimecmp <= '0;
		else if (wr.we && csr_addr_e'(wr.addr) == csr_mnecycle)
			mtimecmp <= {{(time_w-xlen){1'b0}}, wr.data};	// low word only
	end

	// compare result of the previous edge
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			m_timer <= 1'b0;
		else
			m_timer <= (count >= mtimecmp);
	end

endmodule

// ==== csr_read_mux.sv ====
`timescale 1ns/1ps

module csr_read_mux
	import csr_pkg::*;
(
	input  logic [csr_addr_w-1:0] csr_addr_r,
	input  status_t               status,
	input  logic [15:0]           medeleg,
	input  logic [11:0]           mideleg,
	input  logic [time_w-1:0]     count,
	input  logic [time_w-1:0]     mtimecmp,
	input  logic                  m_timer,
	input  logic                  m_interrupt,
	input  logic                  s_interrupt,
	input  logic [xlen-1:0]       bank_m_rdata,
	input  logic                  bank_m_hit,
	input  logic [xlen-1:0]       bank_s_rdata,
	input  logic                  bank_s_hit,
	output logic [xlen-1:0]       csr_data
);

	logic [xlen-1:0] mstatus_v;
	logic [xlen-1:0] sstatus_v;
	logic [xlen-1:0] mip_v;
	logic [xlen-1:0] sip_v;
	logic [xlen-1:0] mie_v;
	logic [xlen-1:0] sie_v;

	assign mstatus_v = {9'b0, status.tsr, 3'b0, status.sum, 5'b0, status.mpp, 2'b0,
		status.spp, status.mpie, 1'b0, status.spie, 1'b0, status.mie, 1'b0, status.sie, 1'b0};

	// restricted view of mstatus
	assign sstatus_v = {13'b0, status.sum, 9'b0, status.spp, 2'b0, status.spie, 3'b0,
		status.sie, 1'b0};

	assign mip_v = {20'b0, m_interrupt, 1'b0, s_interrupt, 1'b0, m_timer, 7'b0};
	assign sip_v = {22'b0, s_interrupt, 9'b0};	// no supervisor timer
	assign mie_v = {20'b0, status.meie, 1'b0, status.seie, 1'b0, status.mtie, 1'b0,
		status.stie, 5'b0};
	assign sie_v = {22'b0, status.seie, 3'b0, status.stie, 5'b0};

	always_comb
	begin
		if (bank_m_hit)
			csr_data = bank_m_rdata;
		else if (bank_s_hit)
			csr_data = bank_s_rdata;
		else
		begin
			case (csr_addr_e'(csr_addr_r))
				csr_misa:      csr_data = misa_value;
				csr_mvendorid,
				csr_marchid,
				csr_mimpid,
				csr_mhartid:   csr_data = '0;
				csr_mstatus:   csr_data = mstatus_v;
				csr_sstatus:   csr_data = sstatus_v;
				csr_mip:       csr_data = mip_v;
				csr_sip:       csr_data = sip_v;
				csr_mie:       csr_data = mie_v;
				csr_sie:       csr_data = sie_v;
				csr_medeleg:   csr_data = {16'b0, medeleg};
				csr_mideleg:   csr_data = {20'b0, mideleg};
				csr_time,
				csr_cycle,
				csr_mcycle:    csr_data = count[xlen-1:0];
				csr_timeh,
				csr_cycleh,
				csr_mcycleh:   csr_data = count[time_w-1:xlen];
				csr_mnecycle:  csr_data = mtimecmp[xlen-1:0];
				default:       csr_data = '0;
			endcase
		end
	end

endmodule

// ==== csr_regfile.sv ====
`timescale 1ns/1ps

module csr_regfile
	import csr_pkg::*;
(
	input  logic                  clk,
	input  logic                  nrst,
	input  logic                  csr_we,
	input  logic [csr_addr_w-1:0] csr_addr_r,
	input  logic [csr_addr_w-1:0] csr_addr_wb,
	input  logic [xlen-1:0]       csr_wb,
	input  trap_req_t             trap,
	input  logic                  m_interrupt,
	input  logic                  s_interrupt,
	output logic [xlen-1:0]       csr_data,
	output irq_en_t               irq_en,
	output logic                  m_timer,
	output priv_mode_e            current_mode,
	output logic                  tsr,
	output logic [xlen-1:0]       redirect_pc
);

	csr_write_t        wr;
	trap_act_t         act;
	status_t           status;
	trap_vec_t         m_vec;
	trap_vec_t         s_vec;
	logic [15:0]       medeleg;
	logic [11:0]       mideleg;
	logic [time_w-1:0] count;
	logic [time_w-1:0] mtimecmp;
	logic [xlen-1:0]   bank_m_rdata;
	logic [xlen-1:0]   bank_s_rdata;
	logic              bank_m_hit;
	logic              bank_s_hit;

	// a trap event wins over a csr write in the same cycle
	always_comb
	begin
		wr.we   = csr_we & ~trap.valid;
		wr.addr = csr_addr_wb;
		wr.data = csr_wb;
	end

	csr_trap_ctrl u_trap_ctrl (
		.clk          (clk),
		.nrst         (nrst),
		.wr           (wr),
		.trap         (trap),
		.status       (status),
		.m_vec        (m_vec),
		.s_vec        (s_vec),
		.act          (act),
		.current_mode (current_mode),
		.medeleg      (medeleg),
		.mideleg      (mideleg),
		.redirect_pc  (redirect_pc)
	);

	csr_status u_status (
		.clk    (clk),
		.nrst   (nrst),
		.wr     (wr),
		.act    (act),
		.status (status),
		.irq_en (irq_en)
	);

	csr_trap_bank #(.base(m_base)) m_bank (
		.clk        (clk),
		.nrst       (nrst),
		.wr         (wr),
		.act        (act),
		.trap       (trap),
		.csr_addr_r (csr_addr_r),
		.vec        (m_vec),
		.rdata      (bank_m_rdata),
		.hit        (bank_m_hit)
	);

	csr_trap_bank #(.base(s_base)) s_bank (
		.clk        (clk),
		.nrst       (nrst),
		.wr         (wr),
		.act        (act),
		.trap       (trap),
		.csr_addr_r (csr_addr_r),
		.vec        (s_vec),
		.rdata      (bank_s_rdata),
		.hit        (bank_s_hit)
	);

	csr_timer u_timer (
		.clk      (clk),
		.nrst     (nrst),
		.wr       (wr),
		.count    (count),
		.mtimecmp (mtimecmp),
		.m_timer  (m_timer)
	);

	csr_read_mux u_read_mux (
		.csr_addr_r   (csr_addr_r),
		.status       (status),
		.medeleg      (medeleg),
		.mideleg      (mideleg),
		.count        (count),
		.mtimecmp     (mtimecmp),
		.m_timer      (m_timer),
		.m_interrupt  (m_interrupt),
		.s_interrupt  (s_interrupt),
		.bank_m_rdata (bank_m_rdata),
		.bank_m_hit   (bank_m_hit),
		.bank_s_rdata (bank_s_rdata),
		.bank_s_hit   (bank_s_hit),
		.csr_data     (csr_data)
	);

	assign tsr = status.tsr;	// to decode, traps sret in s-mode

endmodule

// ==== tb_csr_regfile.sv ====
`timescale 1ns/1ps

module tb_csr_regfile
	import csr_pkg::*;
();

	localparam int n_writes     = 150;
	localparam int n_irq        = 20;
	localparam int n_traps      = 60;
	localparam int total_cycles = 10 + n_writes * 2 + n_irq + n_traps * 12 + 80;

	logic            clk;
	logic            nrst;
	logic            csr_we;
	logic [11:0]     csr_addr_r;
	logic [11:0]     csr_addr_wb;
	logic [31:0]     csr_wb;
	trap_req_t       trap;
	logic            m_interrupt;
	logic            s_interrupt;
	logic [31:0]     csr_data;
	irq_en_t         irq_en;
	logic            m_timer;
	priv_mode_e      current_mode;
	logic            tsr;
	logic [31:0]     redirect_pc;

	// reference model with bank index 0 for m and 1 for s
	logic [31:0] tvec_r[2];
	logic [31:0] scratch_r[2];
	logic [31:0] epc_r[2];
	logic [31:0] cause_r[2];
	logic [31:0] tval_r[2];
	logic [15:0] medeleg_r;
	logic [11:0] mideleg_r;
	logic        sie_r, mie_r, spie_r, mpie_r, spp_r, sum_r, tsr_r;
	logic        meie_r, seie_r, mtie_r, stie_r;
	logic [1:0]  mpp_r;
	logic [1:0]  model_mode;
	logic [63:0] model_count;
	logic [63:0] model_mtimecmp;
	logic        model_mtimer;

	int errors = 0;
	int checks = 0;

	logic [11:0] wr_addrs[16] = '{12'h340, 12'h305, 12'h341, 12'h342, 12'h343, 12'h140,
		12'h105, 12'h141, 12'h142, 12'h143, 12'h302, 12'h303, 12'h304, 12'h104, 12'h300, 12'h100};
	int exc_codes[11] = '{0, 1, 2, 3, 4, 5, 6, 7, 8, 9, 11};
	int int_codes[4]  = '{3, 7, 9, 11};

	csr_regfile dut (
		.clk          (clk),
		.nrst         (nrst),
		.csr_we       (csr_we),
		.csr_addr_r   (csr_addr_r),
		.csr_addr_wb  (csr_addr_wb),
		.csr_wb       (csr_wb),
		.trap         (trap),
		.m_interrupt  (m_interrupt),
		.s_interrupt  (s_interrupt),
		.csr_data     (csr_data),
		.irq_en       (irq_en),
		.m_timer      (m_timer),
		.current_mode (current_mode),
		.tsr          (tsr),
		.redirect_pc  (redirect_pc)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// model counter and registered compare flag
	always @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			model_count  <= '0;
			model_mtimer <= 1'b0;
		end
		else
		begin
			model_mtimer <= (model_count >= model_mtimecmp);
			model_count  <= model_count + 1;
		end
	end

	initial
	begin
		#(total_cycles * 20 + 2000);
		$display("timeout: the run did not finish within %0d cycles", total_cycles);
		$display("Test failed");
		$finish;
	end

	task automatic check(input string name, input logic [63:0] exp_v, input logic [63:0] act_v);
		checks++;
		if (act_v !== exp_v)
		begin
			errors++;
			$display("CHECK FAILED %s expected %h actual %h", name, exp_v, act_v);
		end
	endtask

	function automatic void model_write(input logic [11:0] addr, input logic [31:0] data);
		int lvl;
		lvl = (addr[11:8] == 4'h1) ? 1 : 0;
		if (addr[11:8] == 4'h3 || addr[11:8] == 4'h1)
		begin
			case (addr[7:0])
				8'h05: tvec_r[lvl] = {data[31:2], 2'b00};
				8'h40: scratch_r[lvl] = data;
				8'h41: epc_r[lvl] = {data[31:2], 2'b00};
				8'h42: cause_r[lvl] = {data[31], 25'b0, data[5:0]};
				8'h43: tval_r[lvl] = data;
				default: ;
			endcase
		end
		case (addr)
			12'h300:
			begin
				sie_r  = data[1];
				mie_r  = data[3];
				spie_r = data[5];
				mpie_r = data[7];
				spp_r  = data[8];
				if (data[12:11] != 2'b10)	// reserved mode is not kept
					mpp_r = data[12:11];
				sum_r  = data[18];
				tsr_r  = data[22];
			end
			12'h100:
			begin
				sie_r  = data[1];
				spie_r = data[5];
				spp_r  = data[8];
				sum_r  = data[18];
			end
			12'h304:
			begin
				stie_r = data[5];
				mtie_r = data[7];
				seie_r = data[9];
				meie_r = data[11];
			end
			12'h104:
			begin
				stie_r = data[5];
				seie_r = data[9];
			end
			12'h302: medeleg_r = data[15:0];
			12'h303: mideleg_r = data[11:0];
			12'hbbf: model_mtimecmp = {32'b0, data};
			default: ;
		endcase
	endfunction

	function automatic logic [31:0] model_read(input logic [11:0] addr);
		int lvl;
		logic [31:0] v;
		lvl = (addr[11:8] == 4'h1) ? 1 : 0;
		v = '0;
		if (addr[11:8] == 4'h3 || addr[11:8] == 4'h1)
		begin
			case (addr[7:0])
				8'h05: v = tvec_r[lvl];
				8'h40: v = scratch_r[lvl];
				8'h41: v = epc_r[lvl];
				8'h42: v = cause_r[lvl];
				8'h43: v = tval_r[lvl];
				default: ;
			endcase
		end
		case (addr)
			12'h300:
			begin
				v[1]     = sie_r;
				v[3]     = mie_r;
				v[5]     = spie_r;
				v[7]     = mpie_r;
				v[8]     = spp_r;
				v[12:11] = mpp_r;
				v[18]    = sum_r;
				v[22]    = tsr_r;
			end
			12'h100:
			begin
				v[1]  = sie_r;
				v[5]  = spie_r;
				v[8]  = spp_r;
				v[18] = sum_r;
			end
			12'h304:
			begin
				v[5]  = stie_r;
				v[7]  = mtie_r;
				v[9]  = seie_r;
				v[11] = meie_r;
			end
			12'h104:
			begin
				v[5] = stie_r;
				v[9] = seie_r;
			end
			12'h344:
			begin
				v[7]  = model_mtimer;
				v[9]  = s_interrupt;
				v[11] = m_interrupt;
			end
			12'h144: v[9] = s_interrupt;	// sip has no timer bit
			12'h302: v = {16'b0, medeleg_r};
			12'h303: v = {20'b0, mideleg_r};
			12'h301: v = misa_value;
			12'hb00, 12'hc00, 12'hc01: v = model_count[31:0];
			12'hb80, 12'hc80, 12'hc81: v = model_count[63:32];
			12'hbbf: v = model_mtimecmp[31:0];
			default: ;
		endcase
		return v;
	endfunction

	function automatic logic [3:0] exp_irq_en();
		return {meie_r & mie_r, mtie_r & mie_r, seie_r & sie_r, stie_r & sie_r};
	endfunction

	task automatic set_idle();
		csr_we = 1'b0;
		trap   = '0;
	endtask

	task automatic write_csr(input logic [11:0] addr, input logic [31:0] data);
		@(negedge clk);
		set_idle();
		csr_we      = 1'b1;
		csr_addr_wb = addr;
		csr_wb      = data;
		@(posedge clk);
		#1;
		model_write(addr, data);
	endtask

	// one read plus the outputs that follow the model state
	task automatic read_check(input logic [11:0] addr, input string name);
		@(negedge clk);
		set_idle();
		csr_addr_r = addr;
		#1;
		check(name, model_read(addr), csr_data);
		check({name, " mode"}, model_mode, current_mode);
		check({name, " irq_en"}, exp_irq_en(), irq_en);
		check({name, " tsr"}, tsr_r, tsr);
		check({name, " m_timer"}, model_mtimer, m_timer);
		check({name, " redirect"}, (model_mode == 2'b01) ? tvec_r[1] : tvec_r[0], redirect_pc);
	endtask

	task automatic read_value(input logic [11:0] addr, output logic [31:0] v);
		@(negedge clk);
		set_idle();
		csr_addr_r = addr;
		#1 v = csr_data;
	endtask

	task automatic send_trap(input logic [31:0] cause, input logic [31:0] pc, input bit with_write,
		output logic [11:0] waddr);
		logic       deleg;
		logic [4:0] code;
		int         lvl;
		code = cause[4:0];
		if (cause[31])
			deleg = (code < 12) && mideleg_r[code];
		else
			deleg = (code < 16) && medeleg_r[code];
		lvl   = deleg ? 1 : 0;
		waddr = wr_addrs[$urandom_range(15, 0)];
		@(negedge clk);
		set_idle();
		trap.valid = 1'b1;
		trap.cause = cause;
		trap.pc    = pc;
		if (with_write)
		begin
			csr_we      = 1'b1;	// must be dropped by the DUT
			csr_addr_wb = waddr;
			csr_wb      = $urandom;
		end
		#1 check("trap redirect", tvec_r[lvl], redirect_pc);
		@(posedge clk);
		#1;
		epc_r[lvl]   = {pc[31:2], 2'b00};
		cause_r[lvl] = cause;
		tval_r[lvl]  = (!cause[31] && cause[30:0] == 0) ? {pc[31:1], 1'b0} : 32'h0;
		if (deleg)
		begin
			spie_r = sie_r;
			sie_r  = 1'b0;
			spp_r  = model_mode[0];
			model_mode = 2'b01;
		end
		else
		begin
			mpie_r = mie_r;
			mie_r  = 1'b0;
			mpp_r  = model_mode;
			model_mode = 2'b11;
		end
	endtask

	task automatic send_ret(input bit is_m);
		logic [31:0] exp_pc;
		exp_pc = is_m ? epc_r[0] : epc_r[1];
		@(negedge clk);
		set_idle();
		trap.valid = 1'b1;
		trap.m_ret = is_m;
		trap.s_ret = !is_m;
		trap.cause = $urandom;
		trap.pc    = $urandom;
		#1 check(is_m ? "mret redirect" : "sret redirect", exp_pc, redirect_pc);
		@(posedge clk);
		#1;
		if (is_m)
		begin
			model_mode = mpp_r;
			mie_r  = mpie_r;
			mpie_r = 1'b1;
			mpp_r  = 2'b00;
		end
		else
		begin
			model_mode = spp_r ? 2'b01 : 2'b00;
			sie_r  = spie_r;
			spie_r = 1'b1;
			spp_r  = 1'b0;
		end
	endtask

	initial
	begin
		logic [11:0] addr;
		logic [11:0] waddr;
		logic [31:0] cause;
		logic [31:0] v1;
		logic [31:0] v2;
		logic [31:0] seed_val;
		int          lvl;
		int          n;

		seed_val = 32'h14e42b1c;
		seed_val = $urandom(seed_val);
		nrst        = 1'b0;
		csr_we      = 1'b0;
		csr_addr_r  = '0;
		csr_addr_wb = '0;
		csr_wb      = '0;
		trap        = '0;
		m_interrupt = 1'b0;
		s_interrupt = 1'b0;
		for (int i = 0; i < 2; i++)
		begin
			tvec_r[i]    = '0;
			scratch_r[i] = '0;
			epc_r[i]     = '0;
			cause_r[i]   = '0;
			tval_r[i]    = '0;
		end
		{sie_r, mie_r, spie_r, mpie_r, spp_r, sum_r, tsr_r} = '0;
		{meie_r, seie_r, mtie_r, stie_r} = '0;
		medeleg_r      = '0;
		mideleg_r      = '0;
		mpp_r          = 2'b11;
		model_mode     = 2'b11;
		model_mtimecmp = '0;

		// reset values read while nrst is still low
		@(posedge clk);
		@(negedge clk);
		read_check(12'h300, "reset mstatus");
		check("reset mstatus const", 32'h0000_1800, csr_data);
		read_check(12'h301, "reset misa");
		check("reset misa const", misa_value, csr_data);
		read_check(12'hf11, "reset mvendorid");
		read_check(12'hf12, "reset marchid");
		read_check(12'hf13, "reset mimpid");
		read_check(12'hf14, "reset mhartid");
		@(negedge clk);
		nrst = 1'b1;

		repeat (n_writes)
		begin
			addr = wr_addrs[$urandom_range(15, 0)];
			write_csr(addr, $urandom);
			read_check(addr, $sformatf("readback %h", addr));
		end

		for (int i = 0; i < n_irq; i++)
		begin
			@(negedge clk);
			set_idle();
			m_interrupt = $urandom_range(1, 0);
			s_interrupt = $urandom_range(1, 0);
			csr_addr_r  = (i % 2) ? 12'h144 : 12'h344;
			#1 check((i % 2) ? "sip view" : "mip view", model_read(csr_addr_r), csr_data);
		end
		m_interrupt = 1'b0;
		s_interrupt = 1'b0;

		repeat (n_traps)
		begin
			write_csr(12'h302, $urandom);
			write_csr(12'h303, $urandom);
			if ($urandom_range(1, 0))
				write_csr(12'h300, $urandom);
			if ($urandom_range(1, 0))
				cause = {1'b1, 31'(int_codes[$urandom_range(3, 0)])};
			else
				cause = {1'b0, 31'(exc_codes[$urandom_range(10, 0)])};
			send_trap(cause, $urandom, $urandom_range(1, 0), waddr);
			lvl = (model_mode == 2'b01) ? 1 : 0;
			read_check(lvl ? 12'h141 : 12'h341, "trap epc");
			read_check(lvl ? 12'h142 : 12'h342, "trap cause");
			read_check(lvl ? 12'h143 : 12'h343, "trap tval");
			read_check(12'h300, "trap mstatus");
			read_check(waddr, "write during trap");
			if ($urandom_range(1, 0))
			begin
				send_ret($urandom_range(1, 0));
				read_check(12'h300, "ret mstatus");
			end
		end

		read_check(12'hc01, "time");
		read_check(12'hc81, "timeh");
		read_check(12'hb00, "mcycle");
		read_check(12'hc80, "cycleh");
		read_value(12'hc00, v1);
		n = $urandom_range(20, 3);
		repeat (n - 1) @(negedge clk);
		read_value(12'hc00, v2);
		check("cycle delta", n, v2 - v1);

		// compare far above the counter clears the flag two edges on
		write_csr(12'hbbf, model_count[31:0] + 32'h1000_0000);
		check("m_timer one edge after write", model_mtimer, m_timer);
		@(negedge clk);
		set_idle();
		@(posedge clk);
		#1 check("m_timer above counter", 1'b0, m_timer);
		read_check(12'hbbf, "mtimecmp");
		write_csr(12'hbbf, model_count[31:0] - 32'd5);
		@(negedge clk);
		set_idle();
		@(posedge clk);
		#1 check("m_timer below counter", 1'b1, m_timer);
		read_check(12'h344, "mip timer");

		@(negedge clk);
		$display("checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== verilog.f ====
csr_pkg.sv
csr_trap_bank.sv
csr_status.sv
csr_trap_ctrl.sv
csr_timer.sv
csr_read_mux.sv
csr_regfile.sv
tb_csr_regfile.sv
